//--- core_pkg.sv
`default_nettype none

package core_pkg;

  // architectural widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] pc_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // general register count, r0 included
  localparam int NUM_REGS = 32;

  // first instruction lands here after reset
  localparam pc_t RESET_PC = 32'h1c00_0000;
  localparam pc_t PC_STEP  = 32'd4;

endpackage

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_LUI,
    ALU_NONE
  } alu_op_e;

  // 3R major opcodes, inst[31:15]
  localparam logic [16:0] OP_ADD_W = 17'h00020;
  localparam logic [16:0] OP_SUB_W = 17'h00022;
  localparam logic [16:0] OP_SLT   = 17'h00024;
  localparam logic [16:0] OP_AND   = 17'h00029;
  localparam logic [16:0] OP_OR    = 17'h0002a;
  localparam logic [16:0] OP_XOR   = 17'h0002b;

  // 2RI12 form, inst[31:22]
  localparam logic [9:0] OP_ADDI_W = 10'h00a;
  // 1RI20 form, inst[31:25]
  localparam logic [6:0] OP_LU12I_W = 7'h0a;

  // instruction queue
  localparam int IQ_DEPTH = 4;
  localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

  typedef struct packed {
    core_pkg::pc_t   pc;
    core_pkg::inst_t inst;
  } fetch_bus_t;

  typedef struct packed {
    core_pkg::pc_t      pc;
    alu_op_e            alu_op;
    core_pkg::word_t    src_a;
    core_pkg::word_t    src_b;
    core_pkg::reg_idx_t rd;
    logic               we;
  } decode_bus_t;

  // also used for the commit port and both forwarding sources
  typedef struct packed {
    core_pkg::pc_t      pc;
    core_pkg::word_t    result;
    core_pkg::reg_idx_t rd;
    logic               we;
  } exec_bus_t;

endpackage

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  wire                  aclk,
  input  wire                  i_rst_n,
  input  wire                  i_inst_valid,
  input  core_pkg::inst_t      i_inst,
  output logic                 o_inst_ready,
  output logic                 o_out_valid,
  output pipe_pkg::fetch_bus_t o_out,
  input  wire                  i_out_ready
);
  import core_pkg::*;
  import pipe_pkg::*;

  fetch_bus_t            queue_mem [IQ_DEPTH];
  logic [IQ_PTR_W-1:0]   wr_ptr;
  logic [IQ_PTR_W-1:0]   rd_ptr;
  logic [IQ_PTR_W:0]     count;
  pc_t                   next_pc;
  logic                  push;
  logic                  pop;

  assign o_inst_ready = (count != (IQ_PTR_W + 1)'(IQ_DEPTH));
  assign o_out_valid  = (count != '0);
  assign o_out        = queue_mem[rd_ptr];

  assign push = i_inst_valid && o_inst_ready;
  assign pop  = o_out_valid && i_out_ready;

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      next_pc <= RESET_PC;
    end else begin
      if (push) begin
        wr_ptr  <= wr_ptr + 1'b1;
        next_pc <= next_pc + PC_STEP;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // count only moves when exactly one side fires
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // each entry carries the pc it was accepted with
  always_ff @(posedge aclk) begin
    if (push) begin
      queue_mem[wr_ptr] <= '{pc: next_pc, inst: i_inst};
    end
  end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                aclk,
  input  wire                i_rst_n,
  input  core_pkg::reg_idx_t i_raddr_a,
  input  core_pkg::reg_idx_t i_raddr_b,
  output core_pkg::word_t    o_rdata_a,
  output core_pkg::word_t    o_rdata_b,
  input  wire                i_we,
  input  core_pkg::reg_idx_t i_waddr,
  input  core_pkg::word_t    i_wdata
);
  import core_pkg::*;

  word_t regs [NUM_REGS];

  // r0 reads zero, a same-cycle write passes straight through
  function automatic word_t read_port(input reg_idx_t raddr);
    if (raddr == '0) begin
      return '0;
    end
    if (i_we && (i_waddr == raddr)) begin
      return i_wdata;
    end
    return regs[raddr];
  endfunction

  always_comb begin
    o_rdata_a = read_port(i_raddr_a);
    o_rdata_b = read_port(i_raddr_b);
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                   aclk,
  input  wire                   i_rst_n,
  input  wire                   i_in_valid,
  input  pipe_pkg::fetch_bus_t  i_in,
  output logic                  o_in_ready,
  output core_pkg::reg_idx_t    o_rf_raddr_a,
  output core_pkg::reg_idx_t    o_rf_raddr_b,
  input  core_pkg::word_t       i_rf_rdata_a,
  input  core_pkg::word_t       i_rf_rdata_b,
  input  wire                   i_ex_fwd_valid,
  input  pipe_pkg::exec_bus_t   i_ex_fwd,
  input  wire                   i_wb_fwd_valid,
  input  pipe_pkg::exec_bus_t   i_wb_fwd,
  output logic                  o_out_valid,
  output pipe_pkg::decode_bus_t o_out,
  input  wire                   i_out_ready
);
  import core_pkg::*;
  import pipe_pkg::*;

  logic       valid_q;
  fetch_bus_t held_q;
  inst_t      inst;
  reg_idx_t   rd;
  reg_idx_t   rj;
  reg_idx_t   rk;
  alu_op_e    alu_op;
  logic       use_imm;
  word_t      imm;

  assign o_in_ready  = !valid_q || i_out_ready;
  assign o_out_valid = valid_q;

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_in_ready) begin
      valid_q <= i_in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_in_valid && o_in_ready) begin
      held_q <= i_in;
    end
  end

  assign inst = held_q.inst;
  assign rd   = inst[4:0];
  assign rj   = inst[9:5];
  assign rk   = inst[14:10];

  always_comb begin
    alu_op  = ALU_NONE;
    use_imm = 1'b0;
    imm     = '0;
    if (inst[31:15] == OP_ADD_W) begin
      alu_op = ALU_ADD;
    end else if (inst[31:15] == OP_SUB_W) begin
      alu_op = ALU_SUB;
    end else if (inst[31:15] == OP_SLT) begin
      alu_op = ALU_SLT;
    end else if (inst[31:15] == OP_AND) begin
      alu_op = ALU_AND;
    end else if (inst[31:15] == OP_OR) begin
      alu_op = ALU_OR;
    end else if (inst[31:15] == OP_XOR) begin
      alu_op = ALU_XOR;
    end else if (inst[31:22] == OP_ADDI_W) begin
      alu_op  = ALU_ADD;
      use_imm = 1'b1;
      imm     = {{20{inst[21]}}, inst[21:10]};
    end else if (inst[31:25] == OP_LU12I_W) begin
      alu_op  = ALU_LUI;
      use_imm = 1'b1;
      imm     = {inst[24:5], 12'h000};
    end
  end

  // operands resolve on the held item, so the older neighbour is already
  // in execute; youngest producer wins
  function automatic word_t pick_operand(input reg_idx_t idx, input word_t rf_data);
    if (idx == '0) begin
      return '0;
    end
    if (i_ex_fwd_valid && i_ex_fwd.we && (i_ex_fwd.rd == idx)) begin
      return i_ex_fwd.result;
    end
    if (i_wb_fwd_valid && i_wb_fwd.we && (i_wb_fwd.rd == idx)) begin
      return i_wb_fwd.result;
    end
    return rf_data;
  endfunction

  assign o_rf_raddr_a = rj;
  assign o_rf_raddr_b = rk;

  always_comb begin
    o_out.pc     = held_q.pc;
    o_out.alu_op = alu_op;
    o_out.src_a  = pick_operand(rj, i_rf_rdata_a);
    o_out.src_b  = use_imm ? imm : pick_operand(rk, i_rf_rdata_b);
    o_out.rd     = rd;
    o_out.we     = (alu_op != ALU_NONE) && (rd != '0);
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                   aclk,
  input  wire                   i_rst_n,
  input  wire                   i_in_valid,
  input  pipe_pkg::decode_bus_t i_in,
  output logic                  o_in_ready,
  output logic                  o_out_valid,
  output pipe_pkg::exec_bus_t   o_out,
  input  wire                   i_out_ready
);
  import core_pkg::*;
  import pipe_pkg::*;

  logic  valid_q;
  word_t alu_result;

  assign o_in_ready = !valid_q || i_out_ready;

  always_comb begin
    case (i_in.alu_op)
      ALU_ADD: alu_result = i_in.src_a + i_in.src_b;
      ALU_SUB: alu_result = i_in.src_a - i_in.src_b;
      ALU_SLT: alu_result = ($signed(i_in.src_a) < $signed(i_in.src_b)) ? 32'd1 : 32'd0;
      ALU_AND: alu_result = i_in.src_a & i_in.src_b;
      ALU_OR:  alu_result = i_in.src_a | i_in.src_b;
      ALU_XOR: alu_result = i_in.src_a ^ i_in.src_b;
      ALU_LUI: alu_result = i_in.src_b;
      // unsupported encodings
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_in_ready) begin
      valid_q <= i_in_valid;
    end
  end

  // registered result doubles as the youngest forwarding source
  always_ff @(posedge aclk) begin
    if (i_in_valid && o_in_ready) begin
      o_out <= '{pc: i_in.pc, result: alu_result, rd: i_in.rd, we: i_in.we};
    end
  end

  assign o_out_valid = valid_q;

endmodule

`default_nettype wire

//--- writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  wire                 aclk,
  input  wire                 i_rst_n,
  input  wire                 i_in_valid,
  input  pipe_pkg::exec_bus_t i_in,
  output logic                o_in_ready,
  output logic                o_commit_valid,
  output pipe_pkg::exec_bus_t o_commit,
  input  wire                 i_commit_ready,
  output logic                o_rf_we,
  output core_pkg::reg_idx_t  o_rf_waddr,
  output core_pkg::word_t     o_rf_wdata
);

  logic commit_fire;

  assign commit_fire = o_commit_valid && i_commit_ready;
  assign o_in_ready  = !o_commit_valid || i_commit_ready;

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      o_commit_valid <= 1'b0;
    end else if (o_in_ready) begin
      o_commit_valid <= i_in_valid;
    end
  end

  // held until the commit port takes it
  always_ff @(posedge aclk) begin
    if (i_in_valid && o_in_ready) begin
      o_commit <= i_in;
    end
  end

  // register file sees the write only in the retire cycle
  assign o_rf_we    = commit_fire && o_commit.we;
  assign o_rf_waddr = o_commit.rd;
  assign o_rf_wdata = o_commit.result;

endmodule

`default_nettype wire

//--- la32_mini_core.sv
`timescale 1ns/1ps
`default_nettype none

module la32_mini_core (
  input  wire                 aclk,
  input  wire                 i_rst_n,
  input  wire                 i_inst_valid,
  input  core_pkg::inst_t     i_inst,
  output logic                o_inst_ready,
  output logic                o_commit_valid,
  output pipe_pkg::exec_bus_t o_commit,
  input  wire                 i_commit_ready
);
  import core_pkg::*;
  import pipe_pkg::*;

  // fetch to decode
  logic        fs_to_ds_valid;
  fetch_bus_t  fs_to_ds_bus;
  logic        ds_ready;
  // decode to execute
  logic        ds_to_es_valid;
  decode_bus_t ds_to_es_bus;
  logic        es_ready;
  // execute to writeback
  logic        es_to_ws_valid;
  exec_bus_t   es_to_ws_bus;
  logic        ws_ready;
  // register file
  reg_idx_t    rf_raddr_a;
  reg_idx_t    rf_raddr_b;
  word_t       rf_rdata_a;
  word_t       rf_rdata_b;
  logic        rf_we;
  reg_idx_t    rf_waddr;
  word_t       rf_wdata;

  fetch_stage u_fetch (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_inst_ready (o_inst_ready),
    .o_out_valid  (fs_to_ds_valid),
    .o_out        (fs_to_ds_bus),
    .i_out_ready  (ds_ready)
  );

  decode_stage u_decode (
    .aclk           (aclk),
    .i_rst_n        (i_rst_n),
    .i_in_valid     (fs_to_ds_valid),
    .i_in           (fs_to_ds_bus),
    .o_in_ready     (ds_ready),
    .o_rf_raddr_a   (rf_raddr_a),
    .o_rf_raddr_b   (rf_raddr_b),
    .i_rf_rdata_a   (rf_rdata_a),
    .i_rf_rdata_b   (rf_rdata_b),
    .i_ex_fwd_valid (es_to_ws_valid),
    .i_ex_fwd       (es_to_ws_bus),
    .i_wb_fwd_valid (o_commit_valid),
    .i_wb_fwd       (o_commit),
    .o_out_valid    (ds_to_es_valid),
    .o_out          (ds_to_es_bus),
    .i_out_ready    (es_ready)
  );

  register_file u_regfile (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_raddr_a (rf_raddr_a),
    .i_raddr_b (rf_raddr_b),
    .o_rdata_a (rf_rdata_a),
    .o_rdata_b (rf_rdata_b),
    .i_we      (rf_we),
    .i_waddr   (rf_waddr),
    .i_wdata   (rf_wdata)
  );

  execute_stage u_execute (
    .aclk        (aclk),
    .i_rst_n     (i_rst_n),
    .i_in_valid  (ds_to_es_valid),
    .i_in        (ds_to_es_bus),
    .o_in_ready  (es_ready),
    .o_out_valid (es_to_ws_valid),
    .o_out       (es_to_ws_bus),
    .i_out_ready (ws_ready)
  );

  writeback_stage u_writeback (
    .aclk           (aclk),
    .i_rst_n        (i_rst_n),
    .i_in_valid     (es_to_ws_valid),
    .i_in           (es_to_ws_bus),
    .o_in_ready     (ws_ready),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .i_commit_ready (i_commit_ready),
    .o_rf_we        (rf_we),
    .o_rf_waddr     (rf_waddr),
    .o_rf_wdata     (rf_wdata)
  );

endmodule

`default_nettype wire

//--- tb_la32_mini_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module tb_la32_mini_core_properties (
  input wire                 aclk,
  input wire                 i_rst_n,
  input wire                 i_inst_ready,
  input wire                 i_commit_valid,
  input pipe_pkg::exec_bus_t i_commit,
  input wire                 i_commit_ready
);

  // a stalled commit keeps its payload until taken
  commit_stable_a: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (i_commit_valid && !i_commit_ready) |=> (i_commit_valid && $stable(i_commit))
  ) else $error("commit payload changed while the port was stalled");

  // r0 is never a write target
  rd0_no_write_a: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (i_commit_valid && (i_commit.rd == '0)) |-> !i_commit.we
  ) else $error("commit to r0 carries a write enable");

  ready_after_reset_a: assert property (
    @(posedge aclk) $rose(i_rst_n) |-> i_inst_ready
  ) else $error("instruction queue not ready in the first cycle after reset");

endmodule

bind la32_mini_core tb_la32_mini_core_properties u_properties (
  .aclk           (aclk),
  .i_rst_n        (i_rst_n),
  .i_inst_ready   (o_inst_ready),
  .i_commit_valid (o_commit_valid),
  .i_commit       (o_commit),
  .i_commit_ready (i_commit_ready)
);

`default_nettype wire

//--- tb_la32_mini_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_la32_mini_core;
  import core_pkg::*;
  import pipe_pkg::*;

  localparam int MAX_ENTRIES        = 64;
  localparam int FULL_SPEED_COMMITS = 10;
  localparam int DRAIN_CYCLES       = 5;

  // one line of program_input.hex
  typedef struct packed {
    inst_t      inst;
    logic [7:0] we;
    logic [7:0] rd;
    word_t      data;
  } prog_entry_t;

  logic      aclk;
  logic      i_rst_n;
  logic      i_inst_valid;
  inst_t     i_inst;
  logic      o_inst_ready;
  logic      o_commit_valid;
  exec_bus_t o_commit;
  logic      i_commit_ready;

  logic [$bits(prog_entry_t)-1:0] prog_mem [MAX_ENTRIES];
  prog_entry_t scan;
  int          num_entries;
  int          accepted;
  int          retired;
  int          in_flight;
  int          cycle_count;
  int          timeout_limit;
  int          drain_count;
  logic        saw_ready_low;
  integer      seed;

  la32_mini_core dut0 (
    .aclk           (aclk),
    .i_rst_n        (i_rst_n),
    .i_inst_valid   (i_inst_valid),
    .i_inst         (i_inst),
    .o_inst_ready   (o_inst_ready),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .i_commit_ready (i_commit_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic prog_entry_t read_entry(input int idx);
    return prog_entry_t'(prog_mem[idx]);
  endfunction

  function automatic inst_t program_word(input int idx);
    prog_entry_t e;
    e = read_entry(idx);
    return e.inst;
  endfunction

  // pc follows acceptance order
  function automatic exec_bus_t expected_commit(input int idx);
    prog_entry_t e;
    exec_bus_t   exp;
    e          = read_entry(idx);
    exp.pc     = RESET_PC + PC_STEP * pc_t'(idx);
    exp.result = e.data;
    exp.rd     = e.rd[4:0];
    exp.we     = e.we[0];
    return exp;
  endfunction

  task automatic abort_run(input string why);
    $display(">>> FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_commit(input exec_bus_t got, input exec_bus_t exp, input int idx);
    if (got.pc !== exp.pc) begin
      $display("FAILED o_commit.pc entry %0d: got %h expected %h", idx, got.pc, exp.pc);
      abort_run("commit pc mismatch");
    end else if (got.we !== exp.we) begin
      $display("FAILED o_commit.we entry %0d: got %h expected %h", idx, got.we, exp.we);
      abort_run("commit write enable mismatch");
    end else if (got.rd !== exp.rd) begin
      $display("FAILED o_commit.rd entry %0d: got %h expected %h", idx, got.rd, exp.rd);
      abort_run("commit destination mismatch");
    end else if (exp.we && (got.result !== exp.result)) begin
      $display("FAILED o_commit.result entry %0d: got %h expected %h",
               idx, got.result, exp.result);
      abort_run("commit result mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      abort_run({name, " mismatch"});
    end
  endtask

  initial begin
    seed           = 32'h85ae_4426;
    i_rst_n        = 1'b0;
    i_inst_valid   = 1'b0;
    i_inst         = '0;
    i_commit_ready = 1'b0;
    accepted       = 0;
    retired        = 0;
    in_flight      = 0;
    cycle_count    = 0;
    drain_count    = 0;
    saw_ready_low  = 1'b0;
    $readmemh("program_input.hex", prog_mem);
    // an all-ones line ends the program
    num_entries = 0;
    scan = read_entry(0);
    while ((scan.we != 8'hff) && (num_entries < MAX_ENTRIES - 1)) begin
      num_entries = num_entries + 1;
      scan = read_entry(num_entries);
    end
    if ((scan.we != 8'hff) || (num_entries == 0)) begin
      abort_run("program_input.hex is empty or has no end marker");
    end else begin
      timeout_limit = 20 * num_entries + 100;
      repeat (2) @(posedge aclk);
      i_rst_n <= 1'b1;
    end
  end

  always @(posedge aclk) begin
    if (i_rst_n) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_limit) begin
        abort_run($sformatf("timeout, commits stopped after %0d of %0d entries",
                            retired, num_entries));
      end else begin
        // queue holds at least in_flight minus the three stage slots
        in_flight = accepted - retired;
        if (in_flight == 0) begin
          check_bit("o_commit_valid", o_commit_valid, 1'b0);
        end
        if (in_flight < IQ_DEPTH) begin
          check_bit("o_inst_ready", o_inst_ready, 1'b1);
        end else if (in_flight >= IQ_DEPTH + 3) begin
          check_bit("o_inst_ready", o_inst_ready, 1'b0);
        end
        if (!o_inst_ready) begin
          saw_ready_low = 1'b1;
        end

        if (o_commit_valid && i_commit_ready) begin
          if (retired >= num_entries) begin
            abort_run("a commit arrived after the last program entry");
          end else begin
            check_commit(o_commit, expected_commit(retired), retired);
            retired = retired + 1;
          end
        end
        if (i_inst_valid && o_inst_ready) begin
          accepted = accepted + 1;
        end

        if (accepted < num_entries) begin
          i_inst_valid <= 1'b1;
          i_inst       <= program_word(accepted);
        end else begin
          i_inst_valid <= 1'b0;
          i_inst       <= '0;
        end
        // full speed first, then random stalls to fill the queue
        if (retired < FULL_SPEED_COMMITS) begin
          i_commit_ready <= 1'b1;
        end else begin
          i_commit_ready <= (($random(seed) & 3) == 0);
        end

        if (retired == num_entries) begin
          drain_count = drain_count + 1;
          if (drain_count == DRAIN_CYCLES) begin
            if (!saw_ready_low) begin
              abort_run("o_inst_ready never fell, the queue was never full");
            end else begin
              $display(">>> PASS");
              $finish;
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- la32_mini_core.f
core_pkg.sv
pipe_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
la32_mini_core.sv
tb_la32_mini_core_properties.sv
tb_la32_mini_core.sv

//--- Makefile
VERILATOR      ?= verilator
TOP            ?= tb_la32_mini_core
FILELIST       ?= la32_mini_core.f
OBJ_DIR        ?= obj_dir
VERILATOR_OPTS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR VERILATOR_OPTS"

test:
	$(VERILATOR) $(VERILATOR_OPTS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- program_input.hex
// one 80-bit word per line: inst[79:48] we[47:40] rd[39:32] data[31:0]
// data is checked only when we is set; an all-ones line ends the program
142468a1010112345000 // lu12i.w r1, 0x12345
0299e021010112345678 // addi.w r1, r1, 0x678
02bffc020102ffffffff // addi.w r2, r0, -1
15000003010380000000 // lu12i.w r3, 0x80000
02a0006301037ffff800 // addi.w r3, r3, -2048
00100824010412345677 // add.w r4, r1, r2
001104850105ffffffff // sub.w r5, r4, r1
001200a6010600000001 // slt r6, r5, r0
00120467010700000000 // slt r7, r3, r1
00148c28010812345000 // and r8, r1, r3
00151909010912345001 // or r9, r8, r6
0015892a010aedcbaffe // xor r10, r9, r2
0010254b010bffffffff // add.w r11, r10, r9
0011256c010cedcbaffe // sub.w r12, r11, r9
02801420000000000000 // addi.w r0, r1, 5
0010040d010d12345678 // add.w r13, r0, r1
0010842e000e00000000 // unsupported, rd r14
001005ce010e12345678 // add.w r14, r14, r1
15579bc0000000000000 // lu12i.w r0, 0xabcde
0015080f010fffffffff // or r15, r0, r2
029ffdf00110000007fe // addi.w r16, r15, 0x7ff
001241f1011100000001 // slt r17, r15, r16
02bff6310111fffffffe // addi.w r17, r17, -3
0015c2320112fffff800 // xor r18, r17, r16
00114873011380000000 // sub.w r19, r3, r18
00120e74011400000001 // slt r20, r19, r3
00154e95011580000001 // or r21, r20, r19
ffffffffffffffffffff // end of program
